/* hw/sdram_pkg.sv */
package sdram_pkg;

  // {ras_n, cas_n, we_n} as driven on the pins
  typedef enum logic [2:0] {
    cmd_noop = 3'b111,
    cmd_actv = 3'b011,
    cmd_read = 3'b101,
    cmd_wrte = 3'b100,
    cmd_prch = 3'b010,
    cmd_aref = 3'b001
  } sdram_cmd_t;

  // client word address: row 26:15, bank 14:13, column 12:0
  typedef logic [26:0] client_addr_t;

  typedef logic [11:0] row_t;
  typedef logic [1:0]  bank_t;
  typedef logic [12:0] pin_addr_t;    // a10 doubles as the all-banks flag
  typedef logic [13:0] page_t;        // row then bank
  typedef logic [31:0] word_t;
  typedef logic [15:0] beat_t;
  typedef logic [3:0]  timer_t;

  localparam timer_t timer_full = '1; // count at rest, next command free to go

  // read or write, the only commands that move data
  function automatic logic is_access(sdram_cmd_t cmd);
    return (cmd == cmd_read) || (cmd == cmd_wrte);
  endfunction

endpackage

/* hw/bank_timer.sv */
`timescale 1ns/1ps

module bank_timer import sdram_pkg::*; #(
  parameter int t_rcd = 3,
  parameter int t_rp  = 3,
  parameter int t_rfc = 15
) (
  input  logic       CLK,
  input  logic       RST,
  input  logic       change_requested,
  input  sdram_cmd_t next_cmd,
  output logic       change_possible,
  output logic       clock_precharge,
  output logic       page_open
);

  // the count climbs to full, so a reload of 16 - t leaves t cycles to wait
  localparam timer_t reload_rcd = timer_t'(16 - t_rcd);
  localparam timer_t reload_rp  = timer_t'(16 - t_rp);
  localparam timer_t reload_rfc = timer_t'(16 - t_rfc);

  sdram_cmd_t last_cmd;
  logic       last_rw;
  timer_t     count;
  timer_t     since_last;    // cycles since the last accepted command
  timer_t     min_gap;
  logic       same_access;
  logic       accepted;

  assign same_access     = last_rw && (next_cmd == last_cmd);
  assign change_possible = (count == timer_full) || same_access;
  assign accepted        = change_requested && change_possible;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      last_cmd        <= cmd_noop;
      last_rw         <= 1'b0;
      count           <= timer_full;
      clock_precharge <= 1'b0;
      page_open       <= 1'b0;
    end
    else
    begin
      clock_precharge <= 1'b0;
      if (accepted)
      begin
        last_cmd <= next_cmd;
        last_rw  <= is_access(next_cmd);
        // a repeated access restarts the spacing to the next kind of command
        case (next_cmd)
          cmd_actv: count <= reload_rcd;
          cmd_aref: count <= reload_rfc;
          default:  count <= reload_rp;
        endcase
        if (next_cmd == cmd_prch)
        begin
          clock_precharge <= 1'b1;
          page_open       <= 1'b0;
        end
        if (next_cmd == cmd_actv)
          page_open <= 1'b1;
      end
      else if (count != timer_full)
        count <= count + 1'b1;
    end
  end

  // independent gap counter, saturating
  always_ff @(posedge CLK)
  begin
    if (!RST)
      since_last <= timer_full;
    else if (accepted)
      since_last <= '0;
    else if (since_last != timer_full)
      since_last <= since_last + 1'b1;
  end

  always_comb
  begin
    case (last_cmd)
      cmd_actv: min_gap = timer_t'(t_rcd - 1);
      cmd_aref: min_gap = timer_t'(t_rfc - 1);
      default:  min_gap = timer_t'(t_rp - 1);
    endcase
  end

  // a new kind of command waits out the recovery of the previous one
  assert property (@(posedge CLK) disable iff (!RST)
    accepted && !same_access |-> since_last >= min_gap)
  else $error("command accepted before recovery of %s", last_cmd.name());

endmodule

/* hw/command_sequencer.sv */
`timescale 1ns/1ps

module command_sequencer import sdram_pkg::*; (
  input  logic         CLK,
  input  logic         RST,
  input  logic         refresh_strobe,
  input  client_addr_t address_req,
  input  logic         we,
  input  logic         do_act,
  input  logic         change_possible,
  input  logic         clock_precharge,
  input  logic         page_open,
  output sdram_cmd_t   next_cmd,
  output logic         change_requested,
  output logic         command_latched,
  output logic         write_strobe,
  output sdram_cmd_t   sd_cmd,
  output bank_t        sd_ba,
  output pin_addr_t    sd_addr
);

  localparam pin_addr_t prch_all_addr = 13'h0400;   // a10 high, every bank

  sdram_cmd_t   cmd_seq [3];   // slot 0 is offered to the timer
  logic [2:0]   we_seq;
  logic [2:0]   isrow_seq;     // slot carries the row rather than the column
  logic [1:0]   seq_len;       // commands left in the sequence
  client_addr_t addr_lat;
  page_t        page_current;
  logic         refresh_ack;

  logic         refresh_pending;
  logic         accepted;
  logic         page_hit;
  logic         load_access;
  sdram_cmd_t   rw_cmd;
  row_t         row_req;
  bank_t        bank_req;
  row_t         row_lat;
  bank_t        bank_lat;
  pin_addr_t    col_lat;

  assign row_req  = address_req[26:15];
  assign bank_req = address_req[14:13];
  assign row_lat  = addr_lat[26:15];
  assign bank_lat = addr_lat[14:13];
  assign col_lat  = addr_lat[12:0];

  assign refresh_pending = refresh_ack ^ refresh_strobe;   // one toggle, one refresh
  assign rw_cmd          = we ? cmd_wrte : cmd_read;
  assign page_hit        = page_open && ({row_req, bank_req} == page_current);
  assign load_access     = !change_requested && !refresh_pending && do_act;

  assign next_cmd         = cmd_seq[0];
  assign write_strobe     = we_seq[0];
  assign change_requested = (seq_len != 2'd0);
  assign accepted         = change_requested && change_possible;
  assign command_latched  = accepted && is_access(next_cmd);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      cmd_seq[0]  <= cmd_noop;
      cmd_seq[1]  <= cmd_noop;
      cmd_seq[2]  <= cmd_noop;
      we_seq      <= 3'b000;
      isrow_seq   <= 3'b000;
      seq_len     <= 2'd0;
      refresh_ack <= refresh_strobe;
    end
    else if (change_requested)
    begin
      if (change_possible)
      begin
        cmd_seq[0] <= cmd_seq[1];   // advance the queue
        cmd_seq[1] <= cmd_seq[2];
        cmd_seq[2] <= cmd_noop;
        we_seq     <= {1'b0, we_seq[2:1]};
        isrow_seq  <= {1'b0, isrow_seq[2:1]};
        seq_len    <= seq_len - 2'd1;
      end
    end
    else if (refresh_pending)
    begin
      // refresh beats a waiting client
      refresh_ack <= refresh_strobe;
      cmd_seq[0]  <= cmd_prch;
      cmd_seq[1]  <= cmd_aref;
      cmd_seq[2]  <= cmd_noop;
      we_seq      <= 3'b000;
      isrow_seq   <= 3'b000;
      seq_len     <= 2'd2;
    end
    else if (do_act)
    begin
      if (page_hit)
      begin
        cmd_seq[0] <= rw_cmd;   // row already open
        cmd_seq[1] <= cmd_noop;
        cmd_seq[2] <= cmd_noop;
        we_seq     <= {2'b00, we};
        isrow_seq  <= 3'b000;
        seq_len    <= 2'd1;
      end
      else
      begin
        cmd_seq[0] <= cmd_prch;
        cmd_seq[1] <= cmd_actv;
        cmd_seq[2] <= rw_cmd;
        we_seq     <= {we, 2'b00};
        isrow_seq  <= 3'b010;
        seq_len    <= 2'd3;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      sd_cmd       <= cmd_noop;
      page_current <= '0;
    end
    else
    begin
      if (clock_precharge)
        page_current <= '0;
      if (accepted)
      begin
        sd_cmd <= next_cmd;
        if (isrow_seq[0])
          page_current <= {row_lat, bank_lat};   // new open page
      end
      else
        sd_cmd <= cmd_noop;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (load_access)
      addr_lat <= address_req;
    if (accepted)
    begin
      sd_ba <= bank_lat;
      if (next_cmd == cmd_prch)
        sd_addr <= prch_all_addr;
      else if (isrow_seq[0])
        sd_addr <= {row_lat[11:10], 1'b0, row_lat[9:0]};
      else
        sd_addr <= col_lat;
    end
  end

  // the client must still be holding its request when the access is taken
  assert property (@(posedge CLK) disable iff (!RST)
    command_latched |-> do_act)
  else $error("command_latched without a held request");

endmodule

/* hw/data_path.sv */
`timescale 1ns/1ps

module data_path import sdram_pkg::*; #(
  parameter int cas_latency = 2
) (
  input  logic       CLK,
  input  logic       RST,
  input  logic       command_latched,
  input  logic       we,
  input  word_t      data_w,
  input  sdram_cmd_t sd_cmd,
  input  beat_t      sd_dq_in,
  output beat_t      sd_dq_out,
  output logic       sd_dq_oe,
  output logic       sd_dm,
  output word_t      data_r,
  output logic       data_r_valid
);

  localparam int track_len = cas_latency + 2;

  word_t                wr_hold;       // word of the last latched write
  beat_t                wr_high;       // upper half, second beat
  logic                 high_pending;
  logic [track_len-1:0] rd_track;      // bit k set k+1 cycles after READ on sd_cmd
  logic                 wr_on_pins;
  logic                 wr_active;

  assign wr_on_pins   = (sd_cmd == cmd_wrte);
  assign wr_active    = wr_on_pins || high_pending;
  assign data_r_valid = rd_track[track_len-1];

  always_ff @(posedge CLK)
  begin
    if (command_latched && we)
      wr_hold <= data_w;
    if (wr_on_pins)
    begin
      sd_dq_out <= wr_hold[15:0];    // low half first
      wr_high   <= wr_hold[31:16];
    end
    else if (high_pending)
      sd_dq_out <= wr_high;
    if (rd_track[cas_latency-1])
      data_r[15:0] <= sd_dq_in;
    if (rd_track[cas_latency])
      data_r[31:16] <= sd_dq_in;
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      high_pending <= 1'b0;
      sd_dq_oe     <= 1'b0;
      sd_dm        <= 1'b1;          // masked while idle
      rd_track     <= '0;
    end
    else
    begin
      high_pending <= wr_on_pins;
      sd_dq_oe     <= wr_active;
      sd_dm        <= !wr_active;
      rd_track     <= {rd_track[track_len-2:0], sd_cmd == cmd_read};
    end
  end

  // a write burst never collides with a read return on the shared bus
  assert property (@(posedge CLK) disable iff (!RST)
    (rd_track[cas_latency-1] || rd_track[cas_latency]) |-> !sd_dq_oe)
  else $error("data pins driven during a read capture");

endmodule

/* hw/sdram_ctrl.sv */
`timescale 1ns/1ps

module sdram_ctrl import sdram_pkg::*; #(
  parameter int t_rcd       = 3,
  parameter int t_rp        = 3,
  parameter int t_rfc       = 15,
  parameter int cas_latency = 2
) (
  input  logic         CLK,
  input  logic         RST,
  input  client_addr_t address_req,
  input  logic         we,
  input  word_t        data_w,
  input  logic         do_act,
  input  logic         refresh_strobe,
  output logic         command_latched,
  output word_t        data_r,
  output logic         data_r_valid,
  output sdram_cmd_t   sd_cmd,
  output bank_t        sd_ba,
  output pin_addr_t    sd_addr,
  output beat_t        sd_dq_out,
  output logic         sd_dq_oe,
  output logic         sd_dm,
  input  beat_t        sd_dq_in
);

  sdram_cmd_t next_cmd;
  logic       change_requested;
  logic       change_possible;
  logic       clock_precharge;
  logic       page_open;
  logic       write_strobe;

  bank_timer #(
    .t_rcd (t_rcd),
    .t_rp  (t_rp),
    .t_rfc (t_rfc)
  ) bank_timer_i (
    .CLK              (CLK),
    .RST              (RST),
    .change_requested (change_requested),
    .next_cmd         (next_cmd),
    .change_possible  (change_possible),
    .clock_precharge  (clock_precharge),
    .page_open        (page_open)
  );

  command_sequencer command_sequencer_i (
    .CLK              (CLK),
    .RST              (RST),
    .refresh_strobe   (refresh_strobe),
    .address_req      (address_req),
    .we               (we),
    .do_act           (do_act),
    .change_possible  (change_possible),
    .clock_precharge  (clock_precharge),
    .page_open        (page_open),
    .next_cmd         (next_cmd),
    .change_requested (change_requested),
    .command_latched  (command_latched),
    .write_strobe     (write_strobe),
    .sd_cmd           (sd_cmd),
    .sd_ba            (sd_ba),
    .sd_addr          (sd_addr)
  );

  // write flag comes from the sequencer slot of the access
  data_path #(
    .cas_latency (cas_latency)
  ) data_path_i (
    .CLK             (CLK),
    .RST             (RST),
    .command_latched (command_latched),
    .we              (write_strobe),
    .data_w          (data_w),
    .sd_cmd          (sd_cmd),
    .sd_dq_in        (sd_dq_in),
    .sd_dq_out       (sd_dq_out),
    .sd_dq_oe        (sd_dq_oe),
    .sd_dm           (sd_dm),
    .data_r          (data_r),
    .data_r_valid    (data_r_valid)
  );

endmodule

/* tb/sdram_model.sv */
`timescale 1ns/1ps

module sdram_model import sdram_pkg::*; #(
  parameter int cas_latency = 2
) (
  input  logic       CLK,
  input  logic       RST,
  input  sdram_cmd_t sd_cmd,
  input  bank_t      sd_ba,
  input  pin_addr_t  sd_addr,
  input  beat_t      sd_dq_out,
  input  logic       sd_dq_oe,
  input  logic       sd_dm,
  output beat_t      sd_dq_in,
  output logic       fault
);

  beat_t              mem [int];       // beats keyed by bank, row, column, half
  logic [3:0]         open_mask;
  row_t               open_row [4];
  int                 wr_key;
  int                 wr_idx;
  logic [cas_latency-1:0] rd_v;        // bit j set j+1 cycles after READ
  int                 rd_key [cas_latency];
  row_t               row_pins;

  initial fault = 1'b0;
  initial sd_dq_in = '0;

  assign row_pins = {sd_addr[12:11], sd_addr[9:0]};   // a10 skipped on activate

  function automatic int beat_key(bank_t ba, row_t row, pin_addr_t col);
    return int'({ba, row, col, 1'b0});
  endfunction

  task automatic flag(input string msg);
    $display("memory model: %s at %0t", msg, $time);
    fault = 1'b1;
  endtask

  always @(posedge CLK)
  begin
    if (!RST)
    begin
      open_mask <= '0;
      rd_v      <= '0;
      wr_idx    <= 0;
    end
    else
    begin
      if (sd_dq_oe && !sd_dm)
      begin
        mem[wr_key + wr_idx] = sd_dq_out;
        wr_idx <= wr_idx + 1;
      end
      if (sd_cmd == cmd_wrte)
      begin
        wr_key <= beat_key(sd_ba, open_row[sd_ba], sd_addr);
        wr_idx <= 0;
      end
      case (sd_cmd)
        cmd_actv:
        begin
          open_mask[sd_ba] <= 1'b1;
          open_row[sd_ba]  <= row_pins;
        end
        cmd_prch:
          if (sd_addr[10])
            open_mask <= '0;
          else
            open_mask[sd_ba] <= 1'b0;
        default: ;
      endcase
      rd_v      <= {rd_v[cas_latency-2:0], sd_cmd == cmd_read};
      rd_key[0] <= beat_key(sd_ba, open_row[sd_ba], sd_addr);
      for (int j = 1; j < cas_latency; j++)
        rd_key[j] <= rd_key[j-1];
      // low beat in cycle READ+cas, high beat one later
      if (rd_v[cas_latency-2])
        sd_dq_in <= mem.exists(rd_key[cas_latency-2]) ? mem[rd_key[cas_latency-2]] : '0;
      if (rd_v[cas_latency-1])
        sd_dq_in <= mem.exists(rd_key[cas_latency-1] + 1) ? mem[rd_key[cas_latency-1] + 1] : '0;
    end
  end

  assert property (@(posedge CLK) disable iff (!RST)
    (sd_cmd == cmd_read || sd_cmd == cmd_wrte) |-> open_mask[sd_ba])
  else flag("column command to a bank with no open row");

  assert property (@(posedge CLK) disable iff (!RST)
    (sd_cmd == cmd_actv || sd_cmd == cmd_aref) |-> open_mask == 4'b0)
  else flag("activate or refresh while a row is open");

endmodule

/* tb/sdram_ctrl_tb.sv */
`timescale 1ns/1ps

module sdram_ctrl_tb import sdram_pkg::*;;

  localparam int t_rcd       = 3;
  localparam int t_rp        = 3;
  localparam int t_rfc       = 15;
  localparam int cas_latency = 2;
  localparam int n_requests  = 60;
  localparam int max_cycles  = 3000;    // 60 requests x 30 cycles plus refreshes

  logic         CLK = 1'b0;
  logic         RST;
  client_addr_t address_req;
  logic         we;
  word_t        data_w;
  logic         do_act;
  logic         refresh_strobe = 1'b0;
  logic         command_latched;
  word_t        data_r;
  logic         data_r_valid;
  sdram_cmd_t   sd_cmd;
  bank_t        sd_ba;
  pin_addr_t    sd_addr;
  beat_t        sd_dq_out;
  logic         sd_dq_oe;
  logic         sd_dm;
  beat_t        sd_dq_in;
  logic         model_fault;

  word_t        scoreboard [int];
  word_t        exp_fifo [64];          // expected read words in issue order
  int           wr_ptr = 0;
  int           rd_ptr = 0;
  logic         refresh_run = 1'b1;
  int           ref_cnt;
  int           toggles;
  int           aref_count;
  int           cycles = 0;
  logic         act_seen;
  int           issued;
  int           gap;
  sdram_cmd_t   prev_cmd;
  sdram_cmd_t   prev2_cmd;
  logic         prev_a10;
  sdram_cmd_t   cmd_d [8];              // sd_cmd history, index k is k+1 cycles back
  page_t        lat_page;
  pin_addr_t    lat_col;
  page_t        act_page;               // row and bank of the last activate
  page_t        last_acc_page;
  logic         have_acc;
  word_t        lat_data;
  beat_t        beat_lo;
  beat_t        beat_hi;

  always #4 CLK = ~CLK;

  sdram_ctrl #(
    .t_rcd       (t_rcd),
    .t_rp        (t_rp),
    .t_rfc       (t_rfc),
    .cas_latency (cas_latency)
  ) sdram_ctrl_i (.*);

  sdram_model #(.cas_latency(cas_latency)) sdram_model_i (
    .CLK(CLK), .RST(RST), .sd_cmd(sd_cmd), .sd_ba(sd_ba), .sd_addr(sd_addr),
    .sd_dq_out(sd_dq_out), .sd_dq_oe(sd_dq_oe), .sd_dm(sd_dm),
    .sd_dq_in(sd_dq_in), .fault(model_fault)
  );

  task automatic report_error(input string msg);
    $display("ERR %0t: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  function automatic logic column_cmd(sdram_cmd_t c);
    return c == cmd_read || c == cmd_wrte;
  endfunction

  always @(posedge CLK)
  begin
    cycles <= cycles + 1;
    if (cycles == max_cycles)
    begin
      $display("timeout: run did not complete within %0d cycles", max_cycles);
      $display("Test FAILED");
      $fatal(1);
    end
  end

  // one refresh toggle every 40 cycles while stimulus runs
  always @(posedge CLK)
  begin
    if (!RST)
    begin
      ref_cnt <= 0;
      toggles <= 0;
    end
    else if (refresh_run)
    begin
      ref_cnt <= (ref_cnt == 39) ? 0 : ref_cnt + 1;
      if (ref_cnt == 39)
      begin
        refresh_strobe <= ~refresh_strobe;
        toggles        <= toggles + 1;
      end
    end
  end

  always @(posedge CLK)
  begin
    if (!RST)
    begin
      act_seen   <= 1'b0;
      issued     <= 0;
      gap        <= 31;
      prev_cmd   <= cmd_noop;
      prev2_cmd  <= cmd_noop;
      prev_a10   <= 1'b0;
      aref_count <= 0;
      have_acc   <= 1'b0;
      for (int k = 0; k < 8; k++)
        cmd_d[k] <= cmd_noop;
    end
    else
    begin
      act_seen <= act_seen | do_act;
      cmd_d[0] <= sd_cmd;
      for (int k = 1; k < 8; k++)
        cmd_d[k] <= cmd_d[k-1];
      if (sd_cmd != cmd_noop)
      begin
        issued    <= (issued < 3) ? issued + 1 : issued;
        gap       <= 1;
        prev_cmd  <= sd_cmd;
        prev2_cmd <= prev_cmd;
        prev_a10  <= sd_addr[10];
      end
      else if (gap < 31)
        gap <= gap + 1;
      if (sd_cmd == cmd_aref)
      begin
        aref_count <= aref_count + 1;
        have_acc   <= 1'b0;     // refresh closes every row
      end
      if (sd_cmd == cmd_actv)
        act_page <= {sd_addr[12:11], sd_addr[9:0], sd_ba};
      if (column_cmd(sd_cmd))
      begin
        last_acc_page <= lat_page;
        have_acc      <= 1'b1;
      end
      if (command_latched)
      begin
        lat_page <= {address_req[26:15], address_req[14:13]};
        lat_col  <= address_req[12:0];
        lat_data <= data_w;
      end
      if (sd_cmd == cmd_wrte)
      begin
        beat_lo <= lat_data[15:0];
        beat_hi <= lat_data[31:16];
      end
      if (data_r_valid)
        rd_ptr <= rd_ptr + 1;
    end
  end

  assert property (@(posedge CLK) disable iff (!RST) !model_fault)
  else report_error("memory model saw a protocol violation");
  assert property (@(posedge CLK) disable iff (!RST)
    !act_seen |-> sd_cmd == cmd_noop && !sd_dq_oe && !command_latched)
  else report_error("activity before the first request");
  assert property (@(posedge CLK) disable iff (!RST)
    sd_cmd != cmd_noop && issued == 0 |-> sd_cmd == cmd_prch)
  else report_error("first command is not a precharge");
  assert property (@(posedge CLK) disable iff (!RST)
    sd_cmd != cmd_noop && issued == 1 |-> sd_cmd == cmd_actv)
  else report_error("second command is not an activate");
  assert property (@(posedge CLK) disable iff (!RST)
    sd_cmd != cmd_noop && issued == 2 |-> column_cmd(sd_cmd))
  else report_error("third command is not a read or write");
  assert property (@(posedge CLK) disable iff (!RST)
    sd_cmd != cmd_noop && prev_cmd == cmd_actv |-> gap >= t_rcd)
  else report_error("activate to next command below t_rcd");
  assert property (@(posedge CLK) disable iff (!RST)
    sd_cmd != cmd_noop && prev_cmd == cmd_prch |-> gap >= t_rp)
  else report_error("precharge to next command below t_rp");
  assert property (@(posedge CLK) disable iff (!RST)
    sd_cmd != cmd_noop && prev_cmd == cmd_aref |-> gap >= t_rfc)
  else report_error("refresh to next command below t_rfc");
  assert property (@(posedge CLK) disable iff (!RST)
    cmd_d[cas_latency+1] == cmd_read |-> data_r_valid)
  else report_error("missing data_r_valid after READ");
  assert property (@(posedge CLK) disable iff (!RST)
    data_r_valid |-> cmd_d[cas_latency+1] == cmd_read && data_r == exp_fifo[rd_ptr])
  else report_error($sformatf("read data %h, expected %h", data_r, exp_fifo[rd_ptr]));
  assert property (@(posedge CLK) disable iff (!RST)
    column_cmd(sd_cmd) |-> column_cmd(prev_cmd) == (have_acc && lat_page == last_acc_page))
  else report_error("open page not reused, or reused for a different page");
  assert property (@(posedge CLK) disable iff (!RST)
    column_cmd(sd_cmd) && (!have_acc || lat_page != last_acc_page)
      |-> prev_cmd == cmd_actv && prev2_cmd == cmd_prch)
  else report_error("page miss without precharge and activate");
  assert property (@(posedge CLK) disable iff (!RST)
    column_cmd(sd_cmd)
      |-> act_page == lat_page && sd_ba == lat_page[1:0] && sd_addr == lat_col)
  else report_error("access to the wrong row, bank or column");
  assert property (@(posedge CLK) disable iff (!RST)
    sd_cmd == cmd_aref |-> prev_cmd == cmd_prch && prev_a10)
  else report_error("refresh not preceded by a precharge-all");
  assert property (@(posedge CLK) disable iff (!RST)
    cmd_d[0] == cmd_wrte |-> sd_dq_oe && !sd_dm && sd_dq_out == beat_lo)
  else report_error("wrong low write beat");
  assert property (@(posedge CLK) disable iff (!RST)
    cmd_d[1] == cmd_wrte |-> sd_dq_oe && !sd_dm && sd_dq_out == beat_hi)
  else report_error("wrong high write beat");
  assert property (@(posedge CLK) disable iff (!RST)
    cmd_d[0] != cmd_wrte && cmd_d[1] != cmd_wrte |-> !sd_dq_oe && sd_dm)
  else report_error("data pins driven outside a write burst");

  initial
  begin
    int b;
    int r;
    int c;
    logic w;
    client_addr_t a;
    word_t d;
    void'($urandom(84));
    RST         = 1'b0;
    address_req = '0;
    we          = 1'b0;
    data_w      = '0;
    do_act      = 1'b0;
    repeat (3) @(posedge CLK);
    RST <= 1'b1;
    repeat (2) @(posedge CLK);
    for (int i = 0; i < n_requests; i++)
    begin
      b = $urandom % 2;
      r = $urandom % 3;
      c = $urandom % 4;
      a = {row_t'(r + 1), bank_t'(b), 13'(c * 4)};
      w = !scoreboard.exists(int'(a)) || ($urandom % 2 == 1);   // write before read
      d = $urandom;
      address_req <= a;
      we          <= w;
      data_w      <= d;
      do_act      <= 1'b1;
      @(posedge CLK);
      while (!command_latched)
        @(posedge CLK);
      if (w)
        scoreboard[int'(a)] = d;
      else
      begin
        exp_fifo[wr_ptr] = scoreboard[int'(a)];
        wr_ptr = wr_ptr + 1;
      end
    end
    do_act      <= 1'b0;
    refresh_run <= 1'b0;
    repeat (60) @(posedge CLK);   // drain refreshes and read returns
    if (aref_count != toggles || rd_ptr != wr_ptr)
      report_error($sformatf("%0d refreshes for %0d toggles, %0d of %0d reads returned",
                             aref_count, toggles, rd_ptr, wr_ptr));
    else
    begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

/* list.f */
hw/sdram_pkg.sv
hw/bank_timer.sv
hw/command_sequencer.sv
hw/data_path.sv
hw/sdram_ctrl.sv
tb/sdram_model.sv
tb/sdram_ctrl_tb.sv

/* run.sh */
#!/bin/sh
# build and run the SDRAM controller testbench, pass only if the log says so
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sdram_ctrl_tb \
  -f list.f -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
echo "build or simulation returned an error"
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
